// File: logic/zmem_macros.svh
`ifndef ZMEM_MACROS_SVH
`define ZMEM_MACROS_SVH

// cpu side address bus
`define ZA_W 16

// cpu side data bus, one byte
`define ZD_W 8

// page register width, one per 16k window
`define PAGE_W 8

// dram word address: page on top of za[13:1]
`define DA_W 21

// cache index, low bits of the word address
`define CIDX_W 8

`endif

// File: logic/zmem_pkg.sv
package zmem_pkg;

	// cpu bus operation carried with cyc
	typedef enum logic [1:0]
	{
		OP_FETCH = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} bus_op_e;

	// bus cycle controller
	typedef enum logic [1:0]
	{
		C_IDLE   = 2'd0,
		C_LOOKUP = 2'd1,
		C_WAIT   = 2'd2,
		C_DONE   = 2'd3
	} ctrl_state_e;

	// dram slot sequencer
	typedef enum logic [1:0]
	{
		D_IDLE   = 2'd0,
		D_ACCESS = 2'd1,
		D_REPLY  = 2'd2
	} dram_state_e;

endpackage

// File: logic/dram_if.sv
`include "zmem_macros.svh"

interface dram_if;

	// request side, one-cycle strobe
	logic req;
	logic wr;
	logic [`DA_W-1:0] addr;
	// byte lane, 0 is the low byte
	logic wrbsel;
	logic [`ZD_W-1:0] wrdata;

	// answer side, exactly one strobe per req
	logic strobe;
	// read word valid with strobe only
	logic [2*`ZD_W-1:0] rddata;

	// bus cycle controller end
	modport ctrl
	(
		output req, wr, addr, wrbsel, wrdata,
		input strobe, rddata
	);

	// dram controller end
	modport mem
	(
		input req, wr, addr, wrbsel, wrdata,
		output strobe, rddata
	);

endinterface

// File: logic/zmem_pager.sv
`include "zmem_macros.svh"

module zmem_pager import zmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input bus_op_e op,
	input logic [`ZA_W-1:0] za,
	input logic [4*`PAGE_W-1:0] xt_page,
	input logic [3:0] memconf,
	input logic [3:0] cache_en,
	output logic [`DA_W-1:0] daddr,
	output logic wr_ok,
	output logic cache_ok,
	output logic dos
);

	logic [1:0] win;
	logic win0;
	logic [`PAGE_W-1:0] page0;
	logic [`PAGE_W-1:0] page;
	logic fetch;
	logic dos_on;
	logic dos_off;
	logic dos_r;

	// two top address bits pick one of four 16k windows
	assign win = za[`ZA_W-1 -: 2];
	assign win0 = (win == 2'd0);

	// window 0 page
	// memconf[2] set: page register taken as is
	// otherwise rom-style rule, low two bits from ~dos and memconf[0]
	assign page0 = memconf[2] ? xt_page[`PAGE_W-1:0]
		: {xt_page[`PAGE_W-1:2], ~dos_r, memconf[0]};

	always_comb
	begin
		case (win)
			2'd0: page = page0;
			2'd1: page = xt_page[2*`PAGE_W-1 -: `PAGE_W];
			2'd2: page = xt_page[3*`PAGE_W-1 -: `PAGE_W];
			default: page = xt_page[4*`PAGE_W-1 -: `PAGE_W];
		endcase
	end

	// word address, za[0] is the byte lane and is dropped here
	assign daddr = {page, za[`ZA_W-3:1]};

	// window 0 writable only with memconf[1]
	assign wr_ok = !win0 || memconf[1];

	// per window cache enable
	assign cache_ok = cache_en[win];

	// dos tracking on opcode fetches only
	assign fetch = cyc && (op == OP_FETCH);

	// entry into the 3Dxx area of window 0
	// only with the rom-style page rule in force
	assign dos_on = fetch && win0 && (za[`ZA_W-3 -: 6] == 6'h3d)
		&& memconf[0] && !memconf[2];

	// any fetch outside window 0 leaves dos
	assign dos_off = fetch && !win0;

	always_ff @(posedge clk)
	begin
		if (rst)
			dos_r <= 1'b0;
		else if (dos_off)
			dos_r <= 1'b0;
		else if (dos_on)
			dos_r <= 1'b1;
	end

	// registered flag, changes the cycle after the fetch
	assign dos = dos_r;

endmodule

// File: logic/zmem_cache.sv
`include "zmem_macros.svh"

module zmem_cache
(
	input logic clk,
	input logic rst,
	input logic [`DA_W-1:0] lookup_addr,
	input logic fill,
	input logic [2*`ZD_W-1:0] fill_data,
	input logic inval,
	output logic hit_raw,
	output logic [2*`ZD_W-1:0] rd_word
);

	logic [`CIDX_W-1:0] idx;
	logic [`DA_W-`CIDX_W-1:0] tag;

	// address of the previous lookup, used by fill and inval
	logic [`CIDX_W-1:0] idx_r;
	logic [`DA_W-`CIDX_W-1:0] tag_r;

	// entry storage
	logic [`DA_W-`CIDX_W-1:0] tag_mem [0:(1<<`CIDX_W)-1];
	logic [2*`ZD_W-1:0] data_mem [0:(1<<`CIDX_W)-1];
	logic [(1<<`CIDX_W)-1:0] valid;

	// low bits index, upper 13 bits are the tag
	assign idx = lookup_addr[`CIDX_W-1:0];
	assign tag = lookup_addr[`DA_W-1:`CIDX_W];

	// registered lookup, result one cycle after the address
	always_ff @(posedge clk)
	begin
		idx_r <= idx;
		tag_r <= tag;
		rd_word <= data_mem[idx];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			hit_raw <= 1'b0;
		else
			hit_raw <= valid[idx] && (tag_mem[idx] == tag);
	end

	// fill goes to the entry of the held lookup address
	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_mem[idx_r] <= tag_r;
			data_mem[idx_r] <= fill_data;
		end
	end

	// valid bits, cleared entry by entry on reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < (1 << `CIDX_W); i++)
				valid[i] <= 1'b0;
		end
		else if (fill)
			valid[idx_r] <= 1'b1;
		else if (inval)
			valid[idx_r] <= 1'b0;
	end

endmodule

// File: logic/zmem_ctrl.sv
`include "zmem_macros.svh"

module zmem_ctrl import zmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input bus_op_e op,
	input logic za0,
	input logic [`ZD_W-1:0] wdata,
	input logic [`DA_W-1:0] daddr,
	input logic wr_ok,
	input logic cache_ok,
	input logic hit_raw,
	input logic [2*`ZD_W-1:0] rd_word,
	output logic [`DA_W-1:0] lookup_addr,
	output logic fill,
	output logic [2*`ZD_W-1:0] fill_data,
	output logic inval,
	output logic [`ZD_W-1:0] rdata,
	output logic done,
	output logic hit,
	dram_if.ctrl dram
);

	ctrl_state_e state;

	// captured bus cycle
	bus_op_e op_r;
	logic lane_r;
	logic [`ZD_W-1:0] wdata_r;
	logic [`DA_W-1:0] addr_r;
	logic wr_ok_r;
	logic cache_ok_r;

	logic [`ZD_W-1:0] rdata_r;
	logic hit_r;
	logic is_wr;
	logic served;

	// byte lane select, za[0] high picks the upper byte
	function automatic logic [`ZD_W-1:0] lane_byte(input logic [2*`ZD_W-1:0] w, input logic hi);
		return hi ? w[2*`ZD_W-1:`ZD_W] : w[`ZD_W-1:0];
	endfunction

	assign is_wr = (op_r == OP_WRITE);

	// finished without dram
	// read hit in an enabled window, or a protected write
	assign served = is_wr ? !wr_ok_r : (hit_raw && cache_ok_r);

	// live address while idle so the lookup lands in C_LOOKUP
	// then held for fill and inval
	assign lookup_addr = (state == C_IDLE) ? daddr : addr_r;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= C_IDLE;
		else
		begin
			case (state)
				C_IDLE:
					if (cyc)
						state <= C_LOOKUP;
				C_LOOKUP:
					state <= served ? C_DONE : C_WAIT;
				C_WAIT:
					if (dram.strobe)
						state <= C_DONE;
				default:
					state <= C_IDLE;
			endcase
		end
	end

	// cyc outside C_IDLE never gets here
	always_ff @(posedge clk)
	begin
		if (state == C_IDLE && cyc)
		begin
			op_r <= op;
			lane_r <= za0;
			wdata_r <= wdata;
			addr_r <= daddr;
			wr_ok_r <= wr_ok;
			cache_ok_r <= cache_ok;
		end
		// writes never report hit
		if (state == C_LOOKUP)
			hit_r <= !is_wr && hit_raw && cache_ok_r;
		if (state == C_LOOKUP && served && !is_wr)
			rdata_r <= lane_byte(rd_word, lane_r);
		else if (state == C_WAIT && dram.strobe && !is_wr)
			rdata_r <= lane_byte(dram.rddata, lane_r);
	end

	// one-cycle request, fields from the captured cycle
	assign dram.req = (state == C_LOOKUP) && !served;
	assign dram.wr = is_wr;
	assign dram.addr = addr_r;
	assign dram.wrbsel = lane_r;
	assign dram.wrdata = wdata_r;

	// stale entry dropped on an allowed write that hit
	assign inval = (state == C_LOOKUP) && is_wr && wr_ok_r && hit_raw;

	// read data from dram refills the entry
	assign fill = (state == C_WAIT) && dram.strobe && !is_wr && cache_ok_r;
	assign fill_data = dram.rddata;

	assign done = (state == C_DONE);
	assign rdata = rdata_r;
	assign hit = hit_r;

endmodule

// File: logic/dram_ctrl.sv
`include "zmem_macros.svh"

module dram_ctrl import zmem_pkg::*;
(
	input logic clk,
	input logic rst,
	dram_if.mem dram
);

	dram_state_e state;

	// free-running slot counter, one cpu slot per four clocks
	logic [1:0] slot;

	// request waiting for its slot
	logic pend;
	logic accept;

	// latched request
	logic wr_r;
	logic [11:0] a_r;
	logic bsel_r;
	logic [`ZD_W-1:0] wd_r;

	// 4k words, low 12 bits of the word address
	logic [2*`ZD_W-1:0] mem [0:4095];
	logic [2*`ZD_W-1:0] q_r;

	// start only at slot 0
	assign accept = (state == D_IDLE) && pend && (slot == 2'd0);

	always_ff @(posedge clk)
	begin
		if (rst)
			slot <= 2'd0;
		else
			slot <= slot + 2'd1;
	end

	// at most one request in flight, so req and accept never meet
	always_ff @(posedge clk)
	begin
		if (rst)
			pend <= 1'b0;
		else if (accept)
			pend <= 1'b0;
		else if (dram.req)
			pend <= 1'b1;
	end

	// request fields only valid in the req cycle
	always_ff @(posedge clk)
	begin
		if (dram.req)
		begin
			wr_r <= dram.wr;
			a_r <= dram.addr[11:0];
			bsel_r <= dram.wrbsel;
			wd_r <= dram.wrdata;
		end
	end

	// accept -> access -> reply, strobe two clocks after accept
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= D_IDLE;
		else
		begin
			case (state)
				D_IDLE:
					if (accept)
						state <= D_ACCESS;
				D_ACCESS:
					state <= D_REPLY;
				default:
					state <= D_IDLE;
			endcase
		end
	end

	// storage access
	// a write touches only the selected byte lane
	always_ff @(posedge clk)
	begin
		if (state == D_ACCESS)
		begin
			if (wr_r && bsel_r)
				mem[a_r][2*`ZD_W-1:`ZD_W] <= wd_r;
			else if (wr_r)
				mem[a_r][`ZD_W-1:0] <= wd_r;
			q_r <= mem[a_r];
		end
	end

	// word returned with strobe, ignored for writes
	assign dram.strobe = (state == D_REPLY);
	assign dram.rddata = q_r;

endmodule

// File: logic/zmem_top.sv
`include "zmem_macros.svh"

module zmem_top import zmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input bus_op_e op,
	input logic [`ZA_W-1:0] za,
	input logic [`ZD_W-1:0] wdata,
	// four page registers, window 0 in the low byte
	input logic [4*`PAGE_W-1:0] xt_page,
	input logic [3:0] memconf,
	input logic [3:0] cache_en,
	output logic [`ZD_W-1:0] rdata,
	output logic done,
	output logic hit,
	output logic dos
);

	logic [`DA_W-1:0] daddr;
	logic wr_ok;
	logic cache_ok;
	logic [`DA_W-1:0] lookup_addr;
	logic fill;
	logic [2*`ZD_W-1:0] fill_data;
	logic inval;
	logic hit_raw;
	logic [2*`ZD_W-1:0] rd_word;

	// controller to dram link
	dram_if dram_bus ();

	// address mapping and dos flag
	zmem_pager u_pager
	(
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.op(op),
		.za(za),
		.xt_page(xt_page),
		.memconf(memconf),
		.cache_en(cache_en),
		.daddr(daddr),
		.wr_ok(wr_ok),
		.cache_ok(cache_ok),
		.dos(dos)
	);

	// read cache in front of dram
	zmem_cache u_cache
	(
		.clk(clk),
		.rst(rst),
		.lookup_addr(lookup_addr),
		.fill(fill),
		.fill_data(fill_data),
		.inval(inval),
		.hit_raw(hit_raw),
		.rd_word(rd_word)
	);

	// bus cycle fsm
	zmem_ctrl u_ctrl
	(
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.op(op),
		.za0(za[0]),
		.wdata(wdata),
		.daddr(daddr),
		.wr_ok(wr_ok),
		.cache_ok(cache_ok),
		.hit_raw(hit_raw),
		.rd_word(rd_word),
		.lookup_addr(lookup_addr),
		.fill(fill),
		.fill_data(fill_data),
		.inval(inval),
		.rdata(rdata),
		.done(done),
		.hit(hit),
		.dram(dram_bus.ctrl)
	);

	// slot scheduler and word storage
	dram_ctrl u_dram
	(
		.clk(clk),
		.rst(rst),
		.dram(dram_bus.mem)
	);

endmodule

// File: tests/zmem_tb.sv
`include "zmem_macros.svh"

module zmem_tb import zmem_pkg::*;
();

	// about 680 bus cycles at up to 12 clocks each, doubled, plus reset
	localparam int OPS_PLANNED = 680;
	localparam int CYCLE_LIMIT = OPS_PLANNED * 12 * 2 + 400;

	logic clk;
	logic rst;
	logic cyc;
	bus_op_e op;
	logic [`ZA_W-1:0] za;
	logic [`ZD_W-1:0] wdata;
	logic [4*`PAGE_W-1:0] xt_page;
	logic [3:0] memconf;
	logic [3:0] cache_en;
	logic [`ZD_W-1:0] rdata;
	logic done;
	logic hit;
	logic dos;

	// reference byte memory, key is {word address [11:0], lane}
	bit [7:0] mem_m [int];
	// reference cache tags
	bit c_valid [0:255];
	bit [12:0] c_tag [0:255];
	// cached bytes by {entry, lane}, bit 8 set when the value is known
	bit [8:0] c_byte [0:511];
	bit dos_m;

	bit [31:0] rng;
	// bus cycle seen on the pins and not yet answered
	bit open_cyc;
	int cycles = 0;
	int checks;
	int errors;
	int t_checks;
	int t_errors;

	zmem_top uut
	(
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.op(op),
		.za(za),
		.wdata(wdata),
		.xt_page(xt_page),
		.memconf(memconf),
		.cache_en(cache_en),
		.rdata(rdata),
		.done(done),
		.hit(hit),
		.dos(dos)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// xorshift32
	function automatic bit [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// window page rule, window 0 follows dos unless memconf[2]
	function automatic bit [20:0] map_addr(input bit [15:0] a);
		bit [7:0] pg;
		case (a[15:14])
			2'd0: pg = memconf[2] ? xt_page[7:0] : {xt_page[7:2], ~dos_m, memconf[0]};
			2'd1: pg = xt_page[15:8];
			2'd2: pg = xt_page[23:16];
			default: pg = xt_page[31:24];
		endcase
		return {pg, a[13:1]};
	endfunction

	// storage only sees the low 12 word address bits
	function automatic int mem_key(input bit [20:0] da, input bit lane);
		return {19'd0, da[11:0], lane};
	endfunction

	function automatic bit [8:0] mem_byte(input int k);
		if (mem_m.exists(k))
			return {1'b1, mem_m[k]};
		else
			return 9'd0;
	endfunction

	task automatic check_val(input string name, input bit [7:0] exp, input bit [7:0] got);
		checks++;
		assert (got == exp) else
		begin
			$display("FAIL t=%0t %s expected %02h got %02h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - t_checks,
			errors - t_errors);
		t_checks = checks;
		t_errors = errors;
	endtask

	task automatic finish_run();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// one bus cycle, model first, then dut checked at done
	task automatic run_op(input bus_op_e o, input bit [15:0] a, input bit [7:0] d);
		bit [20:0] da;
		bit [7:0] idx;
		bit lane;
		bit chit;
		bit exp_hit;
		bit fast;
		bit [8:0] exp;
		int k;
		int waited;
		// mapped with the dos flag from before this fetch
		da = map_addr(a);
		idx = da[7:0];
		lane = a[0];
		k = mem_key(da, lane);
		chit = c_valid[idx] && (c_tag[idx] == da[20:8]);
		exp_hit = 1'b0;
		fast = 1'b0;
		exp = 9'd0;
		if (o == OP_WRITE)
		begin
			if (a[15:14] != 2'd0 || memconf[1])
			begin
				mem_m[k] = d;
				// write hit drops the entry, enabled or not
				if (chit)
					c_valid[idx] = 1'b0;
			end
			else
				fast = 1'b1;
		end
		else if (chit && cache_en[a[15:14]])
		begin
			exp_hit = 1'b1;
			fast = 1'b1;
			exp = c_byte[{idx, lane}];
		end
		else
		begin
			exp = mem_byte(k);
			// miss in an enabled window refills the whole word
			if (cache_en[a[15:14]])
			begin
				c_valid[idx] = 1'b1;
				c_tag[idx] = da[20:8];
				c_byte[{idx, 1'b0}] = mem_byte(mem_key(da, 1'b0));
				c_byte[{idx, 1'b1}] = mem_byte(mem_key(da, 1'b1));
			end
		end
		if (o == OP_FETCH)
		begin
			if (a[15:14] != 2'd0)
				dos_m = 1'b0;
			else if (a[13:8] == 6'h3d && memconf[0] && !memconf[2])
				dos_m = 1'b1;
		end
		cyc = 1'b1;
		op = o;
		za = a;
		wdata = d;
		@(posedge clk);
		#1;
		cyc = 1'b0;
		waited = 1;
		while (!done && waited < 20)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!done)
		begin
			$display("error at %0t: no done within 20 cycles of cyc", $time);
			errors++;
		end
		else
		begin
			if (o != OP_WRITE && exp[8])
				check_val("rdata", exp[7:0], rdata);
			check_val("hit", {7'd0, exp_hit}, {7'd0, hit});
			check_val("dos", {7'd0, dos_m}, {7'd0, dos});
			// hits and blocked writes skip dram
			if (fast)
				check_val("done latency", 8'd2, waited[7:0]);
		end
		@(posedge clk);
		#1;
		// done is one pulse per cyc
		if (done)
		begin
			$display("error at %0t: done held for more than one cycle", $time);
			errors++;
		end
	endtask

	task automatic test_rw();
		bit [31:0] r;
		memconf = 4'b0110;
		cache_en = 4'hf;
		for (int i = 0; i < 100; i++)
		begin
			xt_page = next_rand();
			r = next_rand();
			run_op(OP_WRITE, r[15:0], r[23:16]);
			run_op(OP_READ, r[15:0], 8'd0);
		end
	endtask

	task automatic test_alias();
		bit [31:0] r;
		bit [31:0] s;
		memconf = 4'b0110;
		cache_en = 4'hf;
		for (int i = 0; i < 20; i++)
		begin
			r = next_rand();
			s = next_rand();
			// windows 1 and 2 on one page
			xt_page = {r[7:0], r[31:24], r[31:24], r[15:8]};
			run_op(OP_WRITE, {2'b01, s[13:0]}, s[23:16]);
			run_op(OP_READ, {2'b10, s[13:0]}, 8'd0);
			// same page means same tag, so window 1 hits the entry
			run_op(OP_READ, {2'b01, s[13:0]}, 8'd0);
		end
	endtask

	task automatic test_wprot();
		bit [31:0] r;
		bit [15:0] a;
		cache_en = 4'hf;
		xt_page = next_rand();
		for (int i = 0; i < 10; i++)
		begin
			r = next_rand();
			a = {2'b00, r[13:0]};
			memconf = 4'b0110;
			run_op(OP_WRITE, a, r[23:16]);
			// protected, value must stay
			memconf = 4'b0100;
			run_op(OP_WRITE, a, ~r[23:16]);
			run_op(OP_READ, a, 8'd0);
			memconf = 4'b0110;
			run_op(OP_WRITE, a, r[31:24]);
			run_op(OP_READ, a, 8'd0);
		end
	endtask

	task automatic test_cache();
		bit [31:0] r;
		bit [15:0] a;
		bit [15:0] b;
		memconf = 4'b0110;
		for (int i = 0; i < 20; i++)
		begin
			cache_en = 4'hf;
			xt_page = next_rand();
			r = next_rand();
			a = r[15:0];
			// same index, other tag and other dram word
			b = a ^ 16'h0200;
			run_op(OP_WRITE, a, r[23:16]);
			run_op(OP_READ, a, 8'd0);
			run_op(OP_READ, a, 8'd0);
			run_op(OP_WRITE, a, r[31:24]);
			run_op(OP_READ, a, 8'd0);
			run_op(OP_WRITE, b, ~r[23:16]);
			run_op(OP_READ, b, 8'd0);
			run_op(OP_READ, a, 8'd0);
			// window of a uncached
			cache_en = ~(4'b0001 << a[15:14]);
			run_op(OP_READ, a, 8'd0);
			run_op(OP_READ, a, 8'd0);
		end
	endtask

	task automatic test_dos();
		bit [31:0] r;
		bit [15:0] w;
		cache_en = 4'hf;
		xt_page = next_rand();
		// rom page rule, window 0 writable
		memconf = 4'b0011;
		for (int i = 0; i < 10; i++)
		begin
			r = next_rand();
			w = {2'b00, r[21:8]};
			run_op(OP_FETCH, {2'b01, r[29:16]}, 8'd0);
			run_op(OP_WRITE, w, r[7:0]);
			run_op(OP_READ, w, 8'd0);
			run_op(OP_FETCH, {2'b00, 6'h3d, r[7:0]}, 8'd0);
			// page bit 1 flips with dos, new tag
			run_op(OP_READ, w, 8'd0);
			// window 0 fetch elsewhere keeps dos
			run_op(OP_FETCH, {2'b00, 6'h10, r[7:0]}, 8'd0);
			run_op(OP_READ, w, 8'd0);
		end
	endtask

	task automatic test_mixed();
		bit [31:0] r;
		bit [31:0] s;
		bus_op_e o;
		for (int i = 0; i < 100; i++)
		begin
			r = next_rand();
			s = next_rand();
			memconf = s[3:0];
			cache_en = s[7:4];
			xt_page = {s[31:24], s[31:24], s[23:16], s[23:16]};
			case (s[9:8])
				2'd0: o = OP_FETCH;
				2'd1: o = OP_WRITE;
				default: o = OP_READ;
			endcase
			run_op(o, {r[15:14], r[31] ? 6'h3d : r[13:8], r[7:0]}, r[23:16]);
		end
	endtask

	// every done must answer a cyc seen on the pins
	always @(posedge clk)
	begin
		if (rst)
			open_cyc <= 1'b0;
		else if (cyc)
			open_cyc <= 1'b1;
		else if (done)
		begin
			if (!open_cyc)
			begin
				$display("error at %0t: done without an open bus cycle", $time);
				errors++;
			end
			open_cyc <= 1'b0;
		end
	end

	// run limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("error: run stopped at the cycle limit of %0d", CYCLE_LIMIT);
			errors++;
			finish_run();
		end
	end

	initial
	begin
		rng = 32'hd7f3_397b;
		rst = 1'b1;
		cyc = 1'b0;
		op = OP_READ;
		za = '0;
		wdata = '0;
		xt_page = '0;
		memconf = 4'd0;
		cache_en = 4'd0;
		dos_m = 1'b0;
		checks = 0;
		errors = 0;
		t_checks = 0;
		t_errors = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		test_rw();
		end_test("rw_random");
		test_alias();
		end_test("page_alias");
		test_wprot();
		end_test("write_protect");
		test_cache();
		end_test("cache");
		test_dos();
		end_test("dos_flag");
		test_mixed();
		end_test("mixed_timing");
		finish_run();
	end

endmodule

// File: src.f
+incdir+logic
logic/zmem_pkg.sv
logic/dram_if.sv
logic/zmem_pager.sv
logic/zmem_cache.sv
logic/zmem_ctrl.sv
logic/dram_ctrl.sv
logic/zmem_top.sv
tests/zmem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the zmem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module zmem_tb -o zmem_sim
./obj_dir/zmem_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
exit 0
